// File: Makefile
TOOL  = verilator
FLAGS = --timing --assert
TOP   = tb_line_axi
FLIST = src.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

# build, run, then judge the run by its log
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

// File: bench/tb_line_axi.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_axi_cfg.svh"

module tb_line_axi;

  localparam int unsigned WORDS     = `LINE_AXI_LINE_WORDS;
  localparam int unsigned DATA_W    = `LINE_AXI_DATA_W;
  localparam int unsigned OFF_W     = $clog2(DATA_W / 8);
  localparam int unsigned MIDX_W    = $clog2(`LINE_AXI_MEM_WORDS);
  localparam int          N_ENTRIES = 11;
  localparam int          TIMEOUT   = 200;

  typedef logic [WORDS-1:0][DATA_W-1:0]   line_t;
  typedef logic [WORDS-1:0][DATA_W/8-1:0] strb_t;

  // one row of the stimulus table
  typedef struct packed {
    line_axi_pkg::req_kind_t     kind;
    logic                        we;
    logic [`LINE_AXI_ADDR_W-1:0] addr;
    strb_t                       be;
    logic                        rand_data;
  } entry_t;

  // --------------------
  // DUT signals
  // --------------------
  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        req_i;
  line_axi_pkg::req_kind_t     kind_i;
  logic                        we_i;
  logic [`LINE_AXI_ADDR_W-1:0] addr_i;
  line_t                       wdata_i;
  strb_t                       be_i;
  logic [`LINE_AXI_ID_W-1:0]   id_i;
  logic                        gnt_o;
  logic                        valid_o;
  line_t                       rdata_o;
  logic [`LINE_AXI_ID_W-1:0]   id_o;
  logic [DATA_W-1:0]           crit_word_o;
  logic                        crit_valid_o;

  // expected memory image, bytes land here under be
  logic [DATA_W-1:0] shadow [`LINE_AXI_MEM_WORDS];
  integer            seed;

  // kind, we, addr, be (word 0 in the low byte), fresh random data
  entry_t table_q [N_ENTRIES] = '{
    '{line_axi_pkg::LINE_REQ,   1'b1, 32'h0000_0100, 32'hFFFF_FFFF, 1'b1},
    '{line_axi_pkg::LINE_REQ,   1'b0, 32'h0000_0100, 32'h0000_0000, 1'b0},
    '{line_axi_pkg::LINE_REQ,   1'b1, 32'h0000_0100, 32'hC33C_F00F, 1'b1},
    '{line_axi_pkg::LINE_REQ,   1'b0, 32'h0000_0110, 32'h0000_0000, 1'b0},
    '{line_axi_pkg::SINGLE_REQ, 1'b1, 32'h0000_0108, 32'h0000_005A, 1'b1},
    '{line_axi_pkg::SINGLE_REQ, 1'b0, 32'h0000_0108, 32'h0000_0000, 1'b0},
    '{line_axi_pkg::LINE_REQ,   1'b1, 32'h0000_07E0, 32'hFFFF_FFFF, 1'b1},
    '{line_axi_pkg::LINE_REQ,   1'b0, 32'h0000_07F8, 32'h0000_0000, 1'b0},
    '{line_axi_pkg::SINGLE_REQ, 1'b1, 32'h0000_07E0, 32'h0000_0081, 1'b1},
    '{line_axi_pkg::SINGLE_REQ, 1'b0, 32'h0000_07E0, 32'h0000_0000, 1'b0},
    '{line_axi_pkg::LINE_REQ,   1'b0, 32'h0000_07E8, 32'h0000_0000, 1'b0}
  };

  string test_name [N_ENTRIES] = '{
    "line_wr_full_a", "line_rd_a_k0", "line_wr_masked_a", "line_rd_a_k2",
    "single_wr_masked", "single_rd_merged", "line_wr_full_b", "line_rd_b_k3",
    "single_wr_b0", "single_rd_b0", "line_rd_b_k1"
  };

  // 8 ns clock
  always #4 clk_i = ~clk_i;

  line_axi_top UUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .kind_i       (kind_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .id_i         (id_i),
    .gnt_o        (gnt_o),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .id_o         (id_o),
    .crit_word_o  (crit_word_o),
    .crit_valid_o (crit_valid_o)
  );

  // --------------------
  // helpers
  // --------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "first error, run stopped");
  endtask

  // 8 byte words, so the word index starts at bit 3
  function automatic logic [MIDX_W-1:0] word_index(input logic [`LINE_AXI_ADDR_W-1:0] addr);
    return addr[OFF_W +: MIDX_W];
  endfunction

  task automatic make_line_data(input logic fresh, output line_t data);
    data = '0;
    if (fresh) begin
      for (int w = 0; w < WORDS; w++) begin
        data[w] = {$random(seed), $random(seed)};
      end
    end
  endtask

  task automatic write_shadow(input entry_t e, input line_t data);
    logic [MIDX_W-1:0] idx;
    int                n;
    idx = word_index(e.addr);
    n   = 1;
    // line writes start at the line base, singles touch one word
    if (e.kind == line_axi_pkg::LINE_REQ) begin
      idx = idx & ~MIDX_W'(WORDS - 1);
      n   = WORDS;
    end
    for (int w = 0; w < n; w++) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (e.be[w][b]) begin
          shadow[idx + MIDX_W'(w)][8*b +: 8] = data[w][8*b +: 8];
        end
      end
    end
  endtask

  // --------------------
  // one table row, issue to completion
  // --------------------
  task automatic run_request(input int i);
    entry_t                    e;
    line_t                     data;
    line_t                     got_line;
    logic [DATA_W-1:0]         got_crit;
    logic [MIDX_W-1:0]         idx;
    logic [MIDX_W-1:0]         base;
    logic [`LINE_AXI_ID_W-1:0] exp_id;
    logic [`LINE_AXI_ID_W-1:0] got_id;
    int                        gnt_cnt;
    int                        crit_cnt;
    int                        wait_cnt;
    logic                      done;
    e        = table_q[i];
    exp_id   = `LINE_AXI_ID_W'(i + 1);
    idx      = word_index(e.addr);
    base     = idx & ~MIDX_W'(WORDS - 1);
    gnt_cnt  = 0;
    crit_cnt = 0;
    wait_cnt = 0;
    done     = 1'b0;
    got_crit = '0;
    make_line_data(e.rand_data, data);

    @(posedge clk_i);
    #1;
    req_i   = 1'b1;
    kind_i  = e.kind;
    we_i    = e.we;
    addr_i  = e.addr;
    wdata_i = data;
    be_i    = e.be;
    id_i    = exp_id;

    // inputs held until the grant
    while (gnt_cnt == 0) begin
      @(negedge clk_i);
      assert (!valid_o) else
        stop_with_error($sformatf("%s completed before it was granted", test_name[i]));
      if (gnt_o) begin
        gnt_cnt++;
      end else if (wait_cnt == TIMEOUT) begin
        stop_with_error($sformatf("%s timed out waiting for gnt_o", test_name[i]));
      end
      wait_cnt++;
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;

    // completion, watching for extra grants and the critical word
    wait_cnt = 0;
    while (!done) begin
      @(negedge clk_i);
      if (gnt_o) begin
        gnt_cnt++;
      end
      if (crit_valid_o) begin
        crit_cnt++;
        got_crit = crit_word_o;
      end
      if (valid_o) begin
        done     = 1'b1;
        got_line = rdata_o;
        got_id   = id_o;
      end else if (wait_cnt == TIMEOUT) begin
        stop_with_error($sformatf("%s timed out waiting for valid_o", test_name[i]));
      end
      wait_cnt++;
    end

    assert (gnt_cnt == 1) else
      stop_with_error($sformatf("error: %s grants expected 1 actual %0d", test_name[i], gnt_cnt));
    assert (got_id === exp_id) else
      stop_with_error($sformatf("error: %s id_o expected %h actual %h",
                                test_name[i], exp_id, got_id));

    if (e.we) begin
      // writes carry no critical word
      assert (crit_cnt == 0) else
        stop_with_error($sformatf("error: %s crit_valid_o pulses expected 0 actual %0d",
                                  test_name[i], crit_cnt));
      write_shadow(e, data);
    end else if (e.kind == line_axi_pkg::LINE_REQ) begin
      // words come back in line order whatever the critical word
      for (int w = 0; w < WORDS; w++) begin
        assert (got_line[w] === shadow[base + MIDX_W'(w)]) else
          stop_with_error($sformatf("error: %s word %0d expected %h actual %h", test_name[i],
                                    w, shadow[base + MIDX_W'(w)], got_line[w]));
      end
      assert (crit_cnt == 1) else
        stop_with_error($sformatf("error: %s crit_valid_o pulses expected 1 actual %0d",
                                  test_name[i], crit_cnt));
      assert (got_crit === shadow[idx]) else
        stop_with_error($sformatf("error: %s crit_word_o expected %h actual %h",
                                  test_name[i], shadow[idx], got_crit));
    end else begin
      assert (crit_cnt == 0) else
        stop_with_error($sformatf("error: %s crit_valid_o pulses expected 0 actual %0d",
                                  test_name[i], crit_cnt));
      assert (got_line[0] === shadow[idx]) else
        stop_with_error($sformatf("error: %s word 0 expected %h actual %h",
                                  test_name[i], shadow[idx], got_line[0]));
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    seed    = 32'h02abdbf9;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    kind_i  = line_axi_pkg::SINGLE_REQ;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    id_i    = '0;

    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // no request yet, so nothing may be granted or completed
    for (int c = 0; c < 4; c++) begin
      @(negedge clk_i);
      assert (!gnt_o && !valid_o && !crit_valid_o) else
        stop_with_error($sformatf("error: idle_after_reset gnt/valid/crit expected 000 actual %b%b%b",
                                  gnt_o, valid_o, crit_valid_o));
    end

    // back to back, each waits for the previous completion
    for (int i = 0; i < N_ENTRIES; i++) begin
      run_request(i);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: include/line_axi_cfg.svh
`ifndef LINE_AXI_CFG_SVH
`define LINE_AXI_CFG_SVH

// byte address width of the request and AXI address channels
`define LINE_AXI_ADDR_W 32

// AXI data width, one word per beat
`define LINE_AXI_DATA_W 64

// words per cache line, 4 x 64 bit = 256 bit line
`define LINE_AXI_LINE_WORDS 4

// transaction id width
`define LINE_AXI_ID_W 4

// sram depth in data words, 512 x 8 byte = 4 KB
`define LINE_AXI_MEM_WORDS 512

// critical word first: 1 = WRAP reads from the request address,
// 0 = INCR reads from the line base
`define LINE_AXI_CWF 0

`endif

// File: src.f
+incdir+include
verilog/line_axi_pkg.sv
verilog/axi_bus_if.sv
verilog/axi_chan_slice.sv
verilog/axi_line_adapter.sv
verilog/axi_sram_slave.sv
verilog/line_axi_top.sv
bench/tb_line_axi.sv

// File: verilog/axi_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_bus_if;

  // write address
  logic                     aw_valid;
  logic                     aw_ready;
  line_axi_pkg::addr_chan_t aw;

  // write data
  logic                     w_valid;
  logic                     w_ready;
  line_axi_pkg::w_chan_t    w;

  // write response
  logic                     b_valid;
  logic                     b_ready;
  line_axi_pkg::b_chan_t    b;

  // read address
  logic                     ar_valid;
  logic                     ar_ready;
  line_axi_pkg::addr_chan_t ar;

  // read data
  logic                     r_valid;
  logic                     r_ready;
  line_axi_pkg::r_chan_t    r;

  modport master (
    output aw_valid, aw, w_valid, w, b_ready, ar_valid, ar, r_ready,
    input  aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r
  );

  modport slave (
    input  aw_valid, aw, w_valid, w, b_ready, ar_valid, ar, r_ready,
    output aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r
  );

endinterface

`default_nettype wire

// File: verilog/axi_chan_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axi_chan_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  // main register drives the output, spare catches one beat on a stall
  logic     main_valid_q;
  logic     spare_valid_q;
  payload_t main_q;
  payload_t spare_q;
  logic     in_fire;
  logic     main_free;

  // ready comes from a flop only, no ready-to-ready path
  assign in_ready_o  = ~spare_valid_q;
  assign in_fire     = in_valid_i & in_ready_o;
  assign main_free   = ~main_valid_q | out_ready_i;
  assign out_valid_o = main_valid_q;
  assign out_data_o  = main_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (main_free) begin
      // spare drains first so order is kept
      main_valid_q  <= spare_valid_q | in_fire;
      spare_valid_q <= 1'b0;
    end else if (in_fire) begin
      spare_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_free) begin
      if (spare_valid_q) begin
        main_q <= spare_q;
      end else if (in_fire) begin
        main_q <= in_data_i;
      end
    end else if (in_fire) begin
      spare_q <= in_data_i;
    end
  end

  // a stalled beat stays put until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

// File: verilog/axi_line_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_axi_cfg.svh"

module axi_line_adapter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   req_i,
  input  line_axi_pkg::req_kind_t                                kind_i,
  input  logic                                                   we_i,
  input  logic [`LINE_AXI_ADDR_W-1:0]                            addr_i,
  input  logic [`LINE_AXI_LINE_WORDS-1:0][`LINE_AXI_DATA_W-1:0]   wdata_i,
  input  logic [`LINE_AXI_LINE_WORDS-1:0][`LINE_AXI_DATA_W/8-1:0] be_i,
  input  logic [`LINE_AXI_ID_W-1:0]                              id_i,
  output logic                                                   gnt_o,
  output logic                                                   valid_o,
  output logic [`LINE_AXI_LINE_WORDS-1:0][`LINE_AXI_DATA_W-1:0]   rdata_o,
  output logic [`LINE_AXI_ID_W-1:0]                              id_o,
  output logic [`LINE_AXI_DATA_W-1:0]                            crit_word_o,
  output logic                                                   crit_valid_o,
  axi_bus_if.master                                              bus
);

  localparam int unsigned WORDS = `LINE_AXI_LINE_WORDS;
  localparam int unsigned IDX_W = $clog2(WORDS);
  localparam int unsigned OFF_W = $clog2(`LINE_AXI_DATA_W / 8);
  localparam int unsigned LINE_OFF_W = IDX_W + OFF_W;
  localparam logic [IDX_W-1:0] LAST = IDX_W'(WORDS - 1);
  localparam bit CWF = `LINE_AXI_CWF;

  typedef enum logic [3:0] {
    IDLE,
    WAIT_AW,
    WAIT_LAST_W,
    WAIT_AW_LAST_W,
    WAIT_AW_BURST,
    WAIT_B,
    WAIT_R,
    WAIT_R_LINE,
    COMPLETE_READ
  } state_t;

  state_t state_q, state_d;

  // beat counter, picks the write word and the read slot
  logic [IDX_W-1:0] cnt_q, cnt_d;
  // word offset of the request address
  logic [IDX_W-1:0] offset_q, offset_d;
  logic [IDX_W-1:0] index;
  logic [WORDS-1:0][`LINE_AXI_DATA_W-1:0] line_q, line_d;
  logic [`LINE_AXI_ID_W-1:0] id_q, id_d;
  logic [`LINE_AXI_ADDR_W-1:0] line_base;
  logic is_line;
  logic aw_req;
  logic w_req;
  logic aw_done;
  logic w_done;

  assign is_line   = (kind_i == line_axi_pkg::LINE_REQ);
  assign line_base = {addr_i[`LINE_AXI_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  assign rdata_o   = line_q;

  // --------------------
  // request fsm
  // --------------------
  always_comb begin
    aw_req       = 1'b0;
    w_req        = 1'b0;
    aw_done      = 1'b0;
    w_done       = 1'b0;
    gnt_o        = 1'b0;
    valid_o      = 1'b0;
    id_o         = id_q;
    crit_word_o  = bus.r.data;
    crit_valid_o = 1'b0;
    bus.b_ready  = 1'b0;
    bus.r_ready  = 1'b0;
    state_d      = state_q;
    cnt_d        = cnt_q;
    offset_d     = offset_q;
    line_d       = line_q;
    id_d         = id_q;
    index        = '0;

    // line writes go out from the line base
    bus.aw.id    = id_i;
    bus.aw.addr  = is_line ? line_base : addr_i;
    bus.aw.len   = is_line ? 8'(WORDS - 1) : 8'd0;
    bus.aw.size  = 3'(OFF_W);
    bus.aw.burst = line_axi_pkg::INCR;

    // wrapping line reads start at the critical word
    bus.ar.id    = id_i;
    bus.ar.addr  = (CWF || !is_line) ? addr_i : line_base;
    bus.ar.len   = is_line ? 8'(WORDS - 1) : 8'd0;
    bus.ar.size  = 3'(OFF_W);
    bus.ar.burst = (CWF && is_line) ? line_axi_pkg::WRAP : line_axi_pkg::INCR;

    // single requests use word 0
    bus.w.data   = is_line ? wdata_i[cnt_q] : wdata_i[0];
    bus.w.strb   = is_line ? be_i[cnt_q] : be_i[0];
    bus.w.last   = !is_line || (cnt_q == LAST);

    bus.ar_valid = 1'b0;

    case (state_q)
      IDLE: begin
        if (req_i && we_i) begin
          aw_req = 1'b1;
          w_req  = 1'b1;
        end else if (req_i) begin
          bus.ar_valid = 1'b1;
          gnt_o        = bus.ar_ready;
          if (bus.ar_ready) begin
            offset_d = addr_i[OFF_W +: IDX_W];
            state_d  = is_line ? WAIT_R_LINE : WAIT_R;
          end
        end
      end

      WAIT_AW_LAST_W: begin
        aw_req = 1'b1;
        w_req  = 1'b1;
      end

      WAIT_LAST_W: begin
        w_req = 1'b1;
      end

      // single data sent, or whole line sent, AW still pending
      WAIT_AW, WAIT_AW_BURST: begin
        aw_req = 1'b1;
      end

      WAIT_B: begin
        bus.b_ready = 1'b1;
        id_o        = bus.b.id;
        if (bus.b_valid) begin
          valid_o = 1'b1;
          cnt_d   = '0;
          state_d = IDLE;
        end
      end

      WAIT_R, WAIT_R_LINE: begin
        bus.r_ready = 1'b1;
        if (bus.r_valid) begin
          if (state_q == WAIT_R_LINE) begin
            // WRAP beats start at the offset, INCR beats at word 0
            index        = CWF ? offset_q + cnt_q : cnt_q;
            crit_valid_o = CWF ? (cnt_q == '0) : (cnt_q == offset_q);
          end
          line_d[index] = bus.r.data;
          cnt_d         = cnt_q + 1'b1;
          if (bus.r.last) begin
            id_d    = bus.r.id;
            state_d = COMPLETE_READ;
          end
        end
      end

      COMPLETE_READ: begin
        valid_o = 1'b1;
        cnt_d   = '0;
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    bus.aw_valid = aw_req;
    bus.w_valid  = w_req;

    // write bookkeeping shared by every write state
    if (aw_req || w_req) begin
      aw_done = (aw_req && bus.aw_ready) || (state_q == WAIT_LAST_W);
      w_done  = (w_req && bus.w_ready && bus.w.last) ||
                (state_q == WAIT_AW) || (state_q == WAIT_AW_BURST);
      if (w_req && bus.w_ready && !bus.w.last) begin
        cnt_d = cnt_q + 1'b1;
      end
      if (aw_done && w_done) begin
        // grant when the later of the two is taken
        gnt_o   = 1'b1;
        state_d = WAIT_B;
      end else if (aw_done) begin
        state_d = WAIT_LAST_W;
      end else if (w_done) begin
        state_d = is_line ? WAIT_AW_BURST : WAIT_AW;
      end else if (state_q == IDLE && (bus.aw_ready || bus.w_ready)) begin
        // some line beats went out, AW not yet
        state_d = WAIT_AW_LAST_W;
      end
    end
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      offset_q <= offset_d;
    end
  end

  always_ff @(posedge clk_i) begin
    line_q <= line_d;
    id_q   <= id_d;
  end

  // the requester holds its request until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_o |=> req_i && $stable({kind_i, we_i, addr_i, wdata_i, be_i, id_i}));

  // more W beats follow a non-last beat, none follow the last one
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.w_valid && bus.w_ready |=> bus.w_valid == !$past(bus.w.last));

endmodule

`default_nettype wire

// File: verilog/axi_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_axi_cfg.svh"

module axi_sram_slave (
  input  logic     clk_i,
  input  logic     rst_ni,
  axi_bus_if.slave bus
);

  localparam int unsigned OFF_W  = $clog2(`LINE_AXI_DATA_W / 8);
  localparam int unsigned MIDX_W = $clog2(`LINE_AXI_MEM_WORDS);

  logic [`LINE_AXI_DATA_W-1:0] mem [`LINE_AXI_MEM_WORDS];

  // next word index of a burst, WRAP stays in the aligned block
  function automatic logic [MIDX_W-1:0] next_word(
    input logic [MIDX_W-1:0]  addr,
    input logic [7:0]         len,
    input line_axi_pkg::burst_t burst
  );
    logic [MIDX_W-1:0] mask;
    mask = MIDX_W'(len);
    case (burst)
      line_axi_pkg::FIXED: return addr;
      line_axi_pkg::WRAP:  return (addr & ~mask) | ((addr + 1'b1) & mask);
      default:             return addr + 1'b1;
    endcase
  endfunction

  // full width beats only, WRAP lengths of 2, 4, 8 or 16
  function automatic logic legal_burst(input line_axi_pkg::addr_chan_t a);
    logic len_ok;
    len_ok = (a.len == 8'd1) || (a.len == 8'd3) || (a.len == 8'd7) || (a.len == 8'd15);
    return (a.size == 3'(OFF_W)) && ((a.burst != line_axi_pkg::WRAP) || len_ok);
  endfunction

  // --------------------
  // write side
  // --------------------
  logic                       aw_got_q;
  logic                       b_valid_q;
  logic [MIDX_W-1:0]          wr_addr_q;
  logic [7:0]                 wr_len_q;
  line_axi_pkg::burst_t       wr_burst_q;
  logic [`LINE_AXI_ID_W-1:0]  wr_id_q;
  logic                       aw_fire;
  logic                       w_fire;
  logic                       b_fire;

  // W waits for its address, one write at a time
  assign bus.aw_ready = ~aw_got_q;
  assign bus.w_ready  = aw_got_q & ~b_valid_q;
  assign bus.b_valid  = b_valid_q;
  assign bus.b.id     = wr_id_q;

  assign aw_fire = bus.aw_valid & bus.aw_ready;
  assign w_fire  = bus.w_valid & bus.w_ready;
  assign b_fire  = bus.b_valid & bus.b_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_got_q  <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_got_q <= 1'b1;
      end else if (b_fire) begin
        aw_got_q <= 1'b0;
      end
      // B the cycle after the last beat lands
      if (w_fire && bus.w.last) begin
        b_valid_q <= 1'b1;
      end else if (b_fire) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      wr_addr_q  <= bus.aw.addr[OFF_W +: MIDX_W];
      wr_len_q   <= bus.aw.len;
      wr_burst_q <= bus.aw.burst;
      wr_id_q    <= bus.aw.id;
    end
    if (w_fire) begin
      // byte lanes under strobe
      for (int b = 0; b < `LINE_AXI_DATA_W / 8; b++) begin
        if (bus.w.strb[b]) begin
          mem[wr_addr_q][8*b +: 8] <= bus.w.data[8*b +: 8];
        end
      end
      wr_addr_q <= next_word(wr_addr_q, wr_len_q, wr_burst_q);
    end
  end

  // --------------------
  // read side
  // --------------------
  logic [8:0]                 rd_left_q;
  logic                       r_valid_q;
  logic [MIDX_W-1:0]          rd_addr_q;
  logic [7:0]                 rd_len_q;
  line_axi_pkg::burst_t       rd_burst_q;
  logic [`LINE_AXI_ID_W-1:0]  rd_id_q;
  logic [`LINE_AXI_DATA_W-1:0] r_data_q;
  logic                       r_last_q;
  logic                       ar_fire;
  logic                       rd_load;

  // a new AR only once the previous burst has fully drained
  assign bus.ar_ready = (rd_left_q == '0) & ~r_valid_q;
  assign bus.r_valid  = r_valid_q;
  assign bus.r.id     = rd_id_q;
  assign bus.r.data   = r_data_q;
  assign bus.r.last   = r_last_q;

  assign ar_fire = bus.ar_valid & bus.ar_ready;
  // fetch the next beat when the output register is empty or taken
  assign rd_load = (rd_left_q != '0) & (~r_valid_q | bus.r_ready);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_left_q <= '0;
      r_valid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        rd_left_q <= {1'b0, bus.ar.len} + 9'd1;
      end else if (rd_load) begin
        rd_left_q <= rd_left_q - 9'd1;
      end
      if (rd_load) begin
        r_valid_q <= 1'b1;
      end else if (bus.r_valid && bus.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      rd_addr_q  <= bus.ar.addr[OFF_W +: MIDX_W];
      rd_len_q   <= bus.ar.len;
      rd_burst_q <= bus.ar.burst;
      rd_id_q    <= bus.ar.id;
    end
    if (rd_load) begin
      r_data_q  <= mem[rd_addr_q];
      r_last_q  <= (rd_left_q == 9'd1);
      rd_addr_q <= next_word(rd_addr_q, rd_len_q, rd_burst_q);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.aw_valid |-> legal_burst(bus.aw));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.ar_valid |-> legal_burst(bus.ar));

endmodule

`default_nettype wire

// File: verilog/line_axi_pkg.sv
`default_nettype none

`include "line_axi_cfg.svh"

package line_axi_pkg;

  // single word or whole cache line
  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_kind_t;

  // AXI burst encodings
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  // shared by AW and AR
  typedef struct packed {
    logic [`LINE_AXI_ID_W-1:0]   id;
    logic [`LINE_AXI_ADDR_W-1:0] addr;
    logic [7:0]                  len;
    logic [2:0]                  size;
    burst_t                      burst;
  } addr_chan_t;

  typedef struct packed {
    logic [`LINE_AXI_DATA_W-1:0]   data;
    logic [`LINE_AXI_DATA_W/8-1:0] strb;
    logic                          last;
  } w_chan_t;

  // no resp field, the slave never errors
  typedef struct packed {
    logic [`LINE_AXI_ID_W-1:0] id;
  } b_chan_t;

  typedef struct packed {
    logic [`LINE_AXI_ID_W-1:0]   id;
    logic [`LINE_AXI_DATA_W-1:0] data;
    logic                        last;
  } r_chan_t;

endpackage

`default_nettype wire

// File: verilog/line_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_axi_cfg.svh"

module line_axi_top (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   req_i,
  input  line_axi_pkg::req_kind_t                                kind_i,
  input  logic                                                   we_i,
  input  logic [`LINE_AXI_ADDR_W-1:0]                            addr_i,
  input  logic [`LINE_AXI_LINE_WORDS-1:0][`LINE_AXI_DATA_W-1:0]   wdata_i,
  input  logic [`LINE_AXI_LINE_WORDS-1:0][`LINE_AXI_DATA_W/8-1:0] be_i,
  input  logic [`LINE_AXI_ID_W-1:0]                              id_i,
  output logic                                                   gnt_o,
  output logic                                                   valid_o,
  output logic [`LINE_AXI_LINE_WORDS-1:0][`LINE_AXI_DATA_W-1:0]   rdata_o,
  output logic [`LINE_AXI_ID_W-1:0]                              id_o,
  output logic [`LINE_AXI_DATA_W-1:0]                            crit_word_o,
  output logic                                                   crit_valid_o
);

  // adapter side and slave side of the register slices
  axi_bus_if bus_m ();
  axi_bus_if bus_s ();

  axi_line_adapter u_adapter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .kind_i       (kind_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .id_i         (id_i),
    .gnt_o        (gnt_o),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .id_o         (id_o),
    .crit_word_o  (crit_word_o),
    .crit_valid_o (crit_valid_o),
    .bus          (bus_m.master)
  );

  // --------------------
  // channel slices
  // --------------------
  axi_chan_slice #(.payload_t(line_axi_pkg::addr_chan_t)) u_aw_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (bus_m.aw_valid),
    .in_ready_o  (bus_m.aw_ready),
    .in_data_i   (bus_m.aw),
    .out_valid_o (bus_s.aw_valid),
    .out_ready_i (bus_s.aw_ready),
    .out_data_o  (bus_s.aw)
  );

  axi_chan_slice #(.payload_t(line_axi_pkg::w_chan_t)) u_w_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (bus_m.w_valid),
    .in_ready_o  (bus_m.w_ready),
    .in_data_i   (bus_m.w),
    .out_valid_o (bus_s.w_valid),
    .out_ready_i (bus_s.w_ready),
    .out_data_o  (bus_s.w)
  );

  axi_chan_slice #(.payload_t(line_axi_pkg::addr_chan_t)) u_ar_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (bus_m.ar_valid),
    .in_ready_o  (bus_m.ar_ready),
    .in_data_i   (bus_m.ar),
    .out_valid_o (bus_s.ar_valid),
    .out_ready_i (bus_s.ar_ready),
    .out_data_o  (bus_s.ar)
  );

  // read data flows slave to adapter
  axi_chan_slice #(.payload_t(line_axi_pkg::r_chan_t)) u_r_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (bus_s.r_valid),
    .in_ready_o  (bus_s.r_ready),
    .in_data_i   (bus_s.r),
    .out_valid_o (bus_m.r_valid),
    .out_ready_i (bus_m.r_ready),
    .out_data_o  (bus_m.r)
  );

  // B goes straight through
  assign bus_m.b_valid = bus_s.b_valid;
  assign bus_m.b       = bus_s.b;
  assign bus_s.b_ready = bus_m.b_ready;

  axi_sram_slave u_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (bus_s.slave)
  );

endmodule

`default_nettype wire
